// ==== sources.f ====
verilog/conv_pkg.sv
verilog/mac_lane.sv
verilog/patch_fetch.sv
verilog/window_buffer.sv
verilog/pool_relu_writer.sv
verilog/conv_accel.sv
test/conv_accel_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f sources.f \
	--top-module conv_accel_tb -o conv_accel_sim
./obj_dir/conv_accel_sim | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"

// ==== test/conv_accel_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module conv_accel_tb;

	localparam int ADDR_W = conv_pkg::ADDR_W;
	localparam int CLK_PERIOD = 4;

	// Pixel sources for a loaded matrix
	localparam int PIX_RAMP = 0;
	localparam int PIX_RANDOM = 1;
	localparam int PIX_POSITIVE = 2;

	logic clk = 1'b0;
	logic reset_b;
	logic dut_run;
	logic dut_busy;
	logic [ADDR_W-1:0] input_sram_read_address;
	logic [15:0] input_sram_read_data = '0;
	logic [ADDR_W-1:0] weights_sram_read_address;
	logic [15:0] weights_sram_read_data = '0;
	logic output_sram_write_enable;
	logic [ADDR_W-1:0] output_sram_write_addresss;
	logic [15:0] output_sram_write_data;

	logic [15:0] in_mem [0:(1<<ADDR_W)-1];
	logic [15:0] wt_mem [0:(1<<ADDR_W)-1];
	logic [15:0] out_mem [0:(1<<ADDR_W)-1];
	logic [15:0] exp_q [$];
	logic [31:0] lfsr = 32'h67fc7f37;
	int load_ptr;
	int budget_words;
	int wr_count;
	int checks;
	int errors;

	conv_accel #(
		.ADDR_W(ADDR_W)
	) dut (
		.clk(clk),
		.reset_b(reset_b),
		.dut_run(dut_run),
		.dut_busy(dut_busy),
		.input_sram_read_address(input_sram_read_address),
		.input_sram_read_data(input_sram_read_data),
		.weights_sram_read_address(weights_sram_read_address),
		.weights_sram_read_data(weights_sram_read_data),
		.output_sram_write_enable(output_sram_write_enable),
		.output_sram_write_addresss(output_sram_write_addresss),
		.output_sram_write_data(output_sram_write_data)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ------------------------------------------------------------------------
	// SRAM models and output capture
	// ------------------------------------------------------------------------

	// Registered reads, data one cycle after the address
	always @(posedge clk) begin
		input_sram_read_data <= in_mem[input_sram_read_address];
		weights_sram_read_data <= wt_mem[weights_sram_read_address];
	end

	always @(negedge clk) begin
		if (reset_b === 1'b1 && output_sram_write_enable) begin
			checks++;
			assert (dut_busy) else begin
				$display("Output write seen while dut_busy is low");
				errors++;
			end
			compare_value("output_sram_write_addresss", 16'(output_sram_write_addresss),
				16'(wr_count));
			out_mem[output_sram_write_addresss] = output_sram_write_data;
			wr_count++;
		end
	end

	// Budget grows with every chain handed to the DUT
	initial begin
		while ($time < 64'(200 + 40 * CLK_PERIOD * budget_words)) @(negedge clk);
		$display("Watchdog timeout, the DUT did not finish its run in time");
		$display("SOME TESTS FAILED");
		$finish;
	end

	task automatic compare_value(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("** Error %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	// ------------------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------------------

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [7:0] random_bits(input int count);
		logic [7:0] v;
		int b;
		v = '0;
		for (b = 0; b < count; b++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[6:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic [7:0] make_pixel(input int kind, input int idx);
		logic [7:0] rb;
		if (kind == PIX_RAMP) begin
			return 8'(idx);
		end
		if (kind == PIX_POSITIVE) begin
			rb = random_bits(6);
			return {1'b0, rb[5:0], 1'b1};
		end
		return random_bits(8);
	endfunction

	task automatic add_matrix(input int n, input int kind);
		int r;
		int c;
		logic [7:0] lo;
		logic [7:0] hi;
		in_mem[load_ptr] = 16'(n);
		for (r = 0; r < n; r++) begin
			for (c = 0; c < n; c += 2) begin
				lo = make_pixel(kind, r * n + c);
				hi = make_pixel(kind, r * n + c + 1);
				in_mem[load_ptr + 1 + (r * n + c) / 2] = {hi, lo};
			end
		end
		load_ptr += 1 + n * n / 2;
	endtask

	task automatic end_chain();
		in_mem[load_ptr] = 16'hffff;
	endtask

	// Every tap the same value, or random when use_random is set
	task automatic load_kernel(input logic use_random, input logic [7:0] value);
		int k;
		for (k = 0; k < (conv_pkg::KERNEL_TAPS + 1) / 2; k++) begin
			wt_mem[k] = '0;
		end
		for (k = 0; k < conv_pkg::KERNEL_TAPS; k++) begin
			wt_mem[k / 2][8 * (k % 2) +: 8] = use_random ? random_bits(8) : value;
		end
	endtask

	// ------------------------------------------------------------------------
	// Reference model
	// ------------------------------------------------------------------------

	function automatic int tap_weight(input int k);
		logic signed [7:0] w;
		w = wt_mem[k / 2][8 * (k % 2) +: 8];
		return int'(w);
	endfunction

	// Even column in the low byte
	function automatic int pixel_at(input int base, input int n, input int r, input int c);
		logic [15:0] word;
		logic signed [7:0] p;
		word = in_mem[base + 1 + (r * n + c) / 2];
		p = word[8 * (c % 2) +: 8];
		return int'(p);
	endfunction

	function automatic int conv_at(input int base, input int n, input int r, input int c);
		int sum;
		int k;
		sum = 0;
		for (k = 0; k < conv_pkg::KERNEL_TAPS; k++) begin
			sum += tap_weight(k) * pixel_at(base, n, r + k / 3, c + k % 3);
		end
		return sum;
	endfunction

	function automatic logic [7:0] pool_result(input int base, input int n, input int i,
		input int j);
		int best;
		int v;
		int q;
		best = conv_at(base, n, 2 * i, 2 * j);
		for (q = 1; q < 4; q++) begin
			v = conv_at(base, n, 2 * i + q / 2, 2 * j + q % 2);
			if (v > best) begin
				best = v;
			end
		end
		if (best < 0) begin
			return 8'd0;
		end
		if (best > conv_pkg::RELU_MAX) begin
			return 8'(conv_pkg::RELU_MAX);
		end
		return 8'(best);
	endfunction

	// Walks the chain in in_mem, returns its length in words
	task automatic build_expected(output int chain_len);
		int addr;
		int n;
		int i;
		int j;
		logic have;
		logic [7:0] first;
		logic [7:0] res;
		exp_q.delete();
		addr = 0;
		while (in_mem[addr] != 16'hffff) begin
			n = int'(in_mem[addr]);
			have = 1'b0;
			for (i = 0; i < (n - 2) / 2; i++) begin
				for (j = 0; j < (n - 2) / 2; j++) begin
					res = pool_result(addr, n, i, j);
					if (have) begin
						exp_q.push_back({first, res});
					end else begin
						first = res;
					end
					have = !have;
				end
			end
			// Lone result closes the matrix with a zero low byte
			if (have) begin
				exp_q.push_back({first, 8'h00});
			end
			addr += 1 + n * n / 2;
		end
		chain_len = addr + 1;
	endtask

	// ------------------------------------------------------------------------
	// Run handling
	// ------------------------------------------------------------------------

	task automatic run_chain();
		int chain_len;
		int i;
		build_expected(chain_len);
		budget_words += chain_len;
		wr_count = 0;
		@(posedge clk);
		dut_run <= 1'b1;
		@(negedge clk);
		while (!dut_busy) @(negedge clk);
		@(posedge clk);
		dut_run <= 1'b0;
		@(negedge clk);
		while (dut_busy) @(negedge clk);
		compare_value("output write count", 16'(wr_count), 16'(exp_q.size()));
		for (i = 0; i < exp_q.size() && i < wr_count; i++) begin
			compare_value($sformatf("output_sram_write_data[%0d]", i), out_mem[i], exp_q[i]);
		end
		repeat (2) @(posedge clk);
	endtask

	// Each result byte must be value, the closing low byte zero
	task automatic expect_bytes(input logic [7:0] value);
		int i;
		for (i = 0; i < wr_count; i++) begin
			compare_value($sformatf("output_sram_write_data[%0d] high byte", i),
				16'(out_mem[i][15:8]), 16'(value));
			compare_value($sformatf("output_sram_write_data[%0d] low byte", i),
				16'(out_mem[i][7:0]), (i == wr_count - 1) ? 16'h0 : 16'(value));
		end
	endtask

	initial begin
		int a;
		reset_b = 1'b0;
		dut_run = 1'b0;
		for (a = 0; a < (1 << ADDR_W); a++) begin
			in_mem[a] = {4'ha, 12'(a)} ^ 16'h0c3c;
			wt_mem[a] = {4'h5, 12'(a)} ^ 16'h3a5a;
		end
		load_kernel(1'b0, 8'h00);
		repeat (10) @(posedge clk);
		reset_b <= 1'b1;

		// Idle after reset until dut_run
		repeat (8) begin
			@(negedge clk);
			compare_value("dut_busy", 16'(dut_busy), 16'h0);
			compare_value("output_sram_write_enable", 16'(output_sram_write_enable), 16'h0);
		end

		// Ramp 4x4 with only the centre tap at 2 gives 2 * x[2][2]
		load_ptr = 0;
		add_matrix(4, PIX_RAMP);
		end_chain();
		wt_mem[2] = 16'h0002;
		run_chain();
		compare_value("output_sram_write_data[0]", out_mem[0], 16'h1400);

		load_ptr = 0;
		add_matrix(8, PIX_RANDOM);
		end_chain();
		load_kernel(1'b1, 8'h00);
		run_chain();
		compare_value("output write count", 16'(wr_count), 16'd5);
		compare_value("output_sram_write_data[4] low byte", 16'(out_mem[4][7:0]), 16'h0);

		// Clamp at both ends
		load_ptr = 0;
		add_matrix(8, PIX_POSITIVE);
		end_chain();
		load_kernel(1'b0, 8'sd127);
		run_chain();
		expect_bytes(8'd127);
		load_kernel(1'b0, -8'sd127);
		run_chain();
		expect_bytes(8'd0);

		// Two matrices in one chain, then the same chain again
		load_ptr = 0;
		add_matrix(4, PIX_RANDOM);
		add_matrix(8, PIX_RANDOM);
		end_chain();
		load_kernel(1'b1, 8'h00);
		run_chain();
		compare_value("output write count", 16'(wr_count), 16'd6);
		run_chain();

		load_ptr = 0;
		end_chain();
		run_chain();

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/conv_accel.sv ====
`timescale 1ns/100ps
`default_nettype none

module conv_accel #(
	parameter int ADDR_W = conv_pkg::ADDR_W
) (
	input  wire logic clk,
	input  wire logic reset_b,
	input  wire logic dut_run,
	output logic dut_busy,
	output logic [ADDR_W-1:0] input_sram_read_address,
	input  wire logic [conv_pkg::DATA_W-1:0] input_sram_read_data,
	output logic [ADDR_W-1:0] weights_sram_read_address,
	input  wire logic [conv_pkg::DATA_W-1:0] weights_sram_read_data,
	output logic output_sram_write_enable,
	output logic [ADDR_W-1:0] output_sram_write_addresss,
	output logic [conv_pkg::DATA_W-1:0] output_sram_write_data
);

	// Fetch to buffer
	logic word_valid;
	logic patch_last;
	logic buf_empty;

	// Buffer to MAC lanes
	conv_pkg::pixel_t weight;
	conv_pkg::pixel_t [conv_pkg::LANES-1:0] pixels;
	logic mac_clear;
	logic mac_en;

	// Lanes and buffer to writer
	conv_pkg::acc_t [conv_pkg::LANES-1:0] acc;
	logic pool_valid;
	logic pool_last;

	patch_fetch #(
		.ADDR_W(ADDR_W)
	) u_fetch (
		.clk(clk),
		.reset_b(reset_b),
		.dut_run(dut_run),
		.input_sram_read_data(input_sram_read_data),
		.buf_empty(buf_empty),
		.dut_busy(dut_busy),
		.input_sram_read_address(input_sram_read_address),
		.word_valid(word_valid),
		.patch_last(patch_last)
	);

	window_buffer #(
		.ADDR_W(ADDR_W)
	) u_buffer (
		.clk(clk),
		.reset_b(reset_b),
		.word_valid(word_valid),
		.patch_last(patch_last),
		.input_sram_read_data(input_sram_read_data),
		.weights_sram_read_data(weights_sram_read_data),
		.buf_empty(buf_empty),
		.weights_sram_read_address(weights_sram_read_address),
		.weight(weight),
		.pixels(pixels),
		.mac_clear(mac_clear),
		.mac_en(mac_en),
		.pool_valid(pool_valid),
		.pool_last(pool_last)
	);

	// One lane per conv output of the pool window
	for (genvar l = 0; l < conv_pkg::LANES; l++) begin : g_lane
		mac_lane u_lane (
			.clk(clk),
			.reset_b(reset_b),
			.mac_clear(mac_clear),
			.mac_en(mac_en),
			.weight(weight),
			.pixel(pixels[l]),
			.acc(acc[l])
		);
	end

	pool_relu_writer #(
		.ADDR_W(ADDR_W)
	) u_writer (
		.clk(clk),
		.reset_b(reset_b),
		.dut_busy(dut_busy),
		.pool_valid(pool_valid),
		.pool_last(pool_last),
		.acc(acc),
		.output_sram_write_enable(output_sram_write_enable),
		.output_sram_write_addresss(output_sram_write_addresss),
		.output_sram_write_data(output_sram_write_data)
	);

endmodule

`default_nettype wire

// ==== verilog/pool_relu_writer.sv ====
`timescale 1ns/100ps
`default_nettype none

module pool_relu_writer #(
	parameter int ADDR_W = conv_pkg::ADDR_W
) (
	input  wire logic clk,
	input  wire logic reset_b,
	input  wire logic dut_busy,
	input  wire logic pool_valid,
	input  wire logic pool_last,
	input  wire conv_pkg::acc_t [conv_pkg::LANES-1:0] acc,
	output logic output_sram_write_enable,
	output logic [ADDR_W-1:0] output_sram_write_addresss,
	output logic [conv_pkg::DATA_W-1:0] output_sram_write_data
);

	conv_pkg::acc_t pool_max;
	logic [7:0] relu;
	logic [7:0] res_q;
	logic [7:0] first_q;
	logic res_valid;
	logic res_last;
	logic have_first;
	logic do_write;
	logic [ADDR_W-1:0] next_addr;

	// ------------------------------------------------------------------------
	// Max pool and clamp
	// ------------------------------------------------------------------------

	always_comb begin
		pool_max = acc[0];
		for (int l = 1; l < conv_pkg::LANES; l++) begin
			if (acc[l] > pool_max) begin
				pool_max = acc[l];
			end
		end
	end

	always_comb begin
		if (pool_max < 0) begin
			relu = 8'd0;
		end else if (pool_max > conv_pkg::RELU_MAX) begin
			relu = 8'(conv_pkg::RELU_MAX);
		end else begin
			relu = pool_max[7:0];
		end
	end

	// ------------------------------------------------------------------------
	// Pair packing
	// ------------------------------------------------------------------------

	// Second of a pair, or a lone result closing the matrix
	assign do_write = res_valid && (have_first || res_last);

	always_ff @(posedge clk) begin
		if (!reset_b) begin
			res_valid <= 1'b0;
			res_last <= 1'b0;
			have_first <= 1'b0;
			output_sram_write_enable <= 1'b0;
			output_sram_write_addresss <= '0;
			next_addr <= '0;
		end else begin
			res_valid <= pool_valid;
			res_last <= pool_last;
			output_sram_write_enable <= do_write;
			if (do_write) begin
				output_sram_write_addresss <= next_addr;
				next_addr <= next_addr + 1'b1;
				have_first <= 1'b0;
			end else if (res_valid) begin
				have_first <= 1'b1;
			end
			// Addresses restart with every run
			if (!dut_busy) begin
				output_sram_write_addresss <= '0;
				next_addr <= '0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (pool_valid) begin
			res_q <= relu;
		end
		if (res_valid && !have_first) begin
			first_q <= res_q;
		end
		if (do_write) begin
			// First result in the high byte
			output_sram_write_data <= have_first ? {first_q, res_q} : {res_q, 8'h00};
		end
	end

endmodule

`default_nettype wire

// ==== verilog/window_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module window_buffer #(
	parameter int ADDR_W = conv_pkg::ADDR_W
) (
	input  wire logic clk,
	input  wire logic reset_b,
	input  wire logic word_valid,
	input  wire logic patch_last,
	input  wire conv_pkg::sram_word_t input_sram_read_data,
	input  wire logic [conv_pkg::DATA_W-1:0] weights_sram_read_data,
	output logic buf_empty,
	output logic [ADDR_W-1:0] weights_sram_read_address,
	output conv_pkg::pixel_t weight,
	output conv_pkg::pixel_t [conv_pkg::LANES-1:0] pixels,
	output logic mac_clear,
	output logic mac_en,
	output logic pool_valid,
	output logic pool_last
);

	localparam logic [1:0] S_EMPTY = 2'd0;
	localparam logic [1:0] S_FILL = 2'd1;
	localparam logic [1:0] S_MULT = 2'd2;

	localparam int BUF_LEN = 2 * conv_pkg::PATCH_WORDS;
	localparam int FILL_W = $clog2(conv_pkg::PATCH_WORDS);
	localparam int TAP_W = $clog2(conv_pkg::KERNEL_TAPS);

	logic [1:0] state;
	logic [FILL_W-1:0] fill_cnt;
	logic [TAP_W-1:0] tap_cnt;
	logic last_q;
	logic final_tap;
	logic [3:0] tap_base;

	// Patch pixel (r, c) ends up at index 4*r + c
	conv_pkg::pixel_t pix_buf [BUF_LEN];

	assign buf_empty = (state == S_EMPTY);
	assign mac_clear = (state == S_EMPTY);
	assign mac_en = (state == S_MULT);
	assign final_tap = mac_en && (tap_cnt == TAP_W'(conv_pkg::KERNEL_TAPS - 1));

	always_ff @(posedge clk) begin
		if (word_valid) begin
			for (int i = 0; i < BUF_LEN - 2; i++) begin
				pix_buf[i] <= pix_buf[i + 2];
			end
			pix_buf[BUF_LEN-2] <= input_sram_read_data.pair[0];
			pix_buf[BUF_LEN-1] <= input_sram_read_data.pair[1];
		end
	end

	// ------------------------------------------------------------------------
	// Fill and tap sequencing
	// ------------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (!reset_b) begin
			state <= S_EMPTY;
			fill_cnt <= '0;
			tap_cnt <= '0;
			last_q <= 1'b0;
			pool_valid <= 1'b0;
			pool_last <= 1'b0;
		end else begin
			pool_valid <= final_tap;
			pool_last <= final_tap && last_q;
			if (word_valid) begin
				fill_cnt <= fill_cnt + 1'b1;
				last_q <= patch_last;
			end
			case (state)
			S_EMPTY: begin
				if (word_valid) begin
					state <= S_FILL;
				end
			end
			S_FILL: begin
				if (word_valid && fill_cnt == FILL_W'(conv_pkg::PATCH_WORDS - 1)) begin
					state <= S_MULT;
					tap_cnt <= '0;
				end
			end
			S_MULT: begin
				tap_cnt <= tap_cnt + 1'b1;
				if (final_tap) begin
					state <= S_EMPTY;
				end
			end
			default: begin
				state <= S_EMPTY;
			end
			endcase
		end
	end

	// Tap 0 weight is requested while the last word lands
	assign weights_sram_read_address = mac_en ? ADDR_W'((tap_cnt + 1'b1) >> 1) : '0;

	// Even taps in the low byte
	assign weight = tap_cnt[0] ? weights_sram_read_data[15:8] : weights_sram_read_data[7:0];

	// Buffer index of kernel offset (k/3, k%3)
	always_comb begin
		case (tap_cnt)
		4'd0: tap_base = 4'd0;
		4'd1: tap_base = 4'd1;
		4'd2: tap_base = 4'd2;
		4'd3: tap_base = 4'd4;
		4'd4: tap_base = 4'd5;
		4'd5: tap_base = 4'd6;
		4'd6: tap_base = 4'd8;
		4'd7: tap_base = 4'd9;
		4'd8: tap_base = 4'd10;
		default: tap_base = 4'd0;
		endcase
	end

	// Lane l sits at conv position (l/2, l%2) of the pool window
	always_comb begin
		for (int l = 0; l < conv_pkg::LANES; l++) begin
			pixels[l] = pix_buf[tap_base + 4'(4 * (l / 2) + (l % 2))];
		end
	end

endmodule

`default_nettype wire

// ==== verilog/patch_fetch.sv ====
`timescale 1ns/100ps
`default_nettype none

module patch_fetch #(
	parameter int ADDR_W = conv_pkg::ADDR_W
) (
	input  wire logic clk,
	input  wire logic reset_b,
	input  wire logic dut_run,
	input  wire conv_pkg::sram_word_t input_sram_read_data,
	input  wire logic buf_empty,
	output logic dut_busy,
	output logic [ADDR_W-1:0] input_sram_read_address,
	output logic word_valid,
	output logic patch_last
);

	localparam logic [2:0] S_IDLE = 3'd0;
	localparam logic [2:0] S_READ_SIZE = 3'd1;
	localparam logic [2:0] S_CHECK_SIZE = 3'd2;
	localparam logic [2:0] S_READ_WORDS = 3'd3;
	localparam logic [2:0] S_DRAIN = 3'd4;

	localparam int WORD_W = $clog2(conv_pkg::PATCH_WORDS);
	localparam int DRAIN_W = $clog2(conv_pkg::DRAIN_CYCLES);

	logic [2:0] state;
	logic [ADDR_W-1:0] base_addr;
	logic [5:0] row;
	logic [5:0] col;
	logic [2:0] log2n;
	logic [WORD_W-1:0] word_idx;
	logic [DRAIN_W-1:0] drain_cnt;

	logic [5:0] n_size;
	logic last_col;
	logic last_row;
	logic fire;
	logic [ADDR_W-1:0] patch_off;
	logic [ADDR_W-1:0] row_off;
	logic [ADDR_W-1:0] patch_addr;
	logic [ADDR_W-1:0] next_base;

	assign dut_busy = (state != S_IDLE);

	assign n_size = 6'd1 << log2n;
	assign last_col = (col == n_size - 6'd4);
	assign last_row = (row == n_size - 6'd4);

	// First word of a patch waits for an empty buffer, the rest stream
	assign fire = (state == S_READ_WORDS) && ((word_idx != '0) || buf_empty);

	// ------------------------------------------------------------------------
	// Address generation
	// ------------------------------------------------------------------------

	// (row * N + col) / 2 words into the pixel area
	assign patch_off = ((ADDR_W'(row) << log2n) + ADDR_W'(col)) >> 1;
	// N/2 words per patch row
	assign row_off = ADDR_W'(word_idx[WORD_W-1:1]) << (log2n - 3'd1);
	assign patch_addr = base_addr + ADDR_W'(1) + patch_off + row_off
		+ ADDR_W'(word_idx[0]);
	// Skip the size word and N*N/2 pixel words
	assign next_base = base_addr + ADDR_W'(1) + (ADDR_W'(1) << ({log2n, 1'b0} - 4'd1));

	assign input_sram_read_address = (state == S_READ_SIZE) ? base_addr : patch_addr;

	// ------------------------------------------------------------------------
	// Run control
	// ------------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (!reset_b) begin
			state <= S_IDLE;
			base_addr <= '0;
			row <= '0;
			col <= '0;
			log2n <= 3'd2;
			word_idx <= '0;
			drain_cnt <= '0;
			word_valid <= 1'b0;
			patch_last <= 1'b0;
		end else begin
			// Strobe lines up with the read data
			word_valid <= fire;
			patch_last <= last_col && last_row;

			case (state)
			S_IDLE: begin
				base_addr <= '0;
				row <= '0;
				col <= '0;
				word_idx <= '0;
				drain_cnt <= '0;
				if (dut_run) begin
					state <= S_READ_SIZE;
				end
			end
			S_READ_SIZE: begin
				state <= S_CHECK_SIZE;
			end
			S_CHECK_SIZE: begin
				if (input_sram_read_data.size == conv_pkg::END_MARKER) begin
					state <= S_DRAIN;
				end else begin
					// N is a power of two, 4 to 32
					if (input_sram_read_data.size[5]) begin
						log2n <= 3'd5;
					end else if (input_sram_read_data.size[4]) begin
						log2n <= 3'd4;
					end else if (input_sram_read_data.size[3]) begin
						log2n <= 3'd3;
					end else begin
						log2n <= 3'd2;
					end
					state <= S_READ_WORDS;
				end
			end
			S_READ_WORDS: begin
				if (fire) begin
					word_idx <= word_idx + 1'b1;
					if (word_idx == WORD_W'(conv_pkg::PATCH_WORDS - 1)) begin
						if (!last_col) begin
							col <= col + 6'd2;
						end else if (!last_row) begin
							col <= '0;
							row <= row + 6'd2;
						end else begin
							// Matrix done, next size word
							col <= '0;
							row <= '0;
							base_addr <= next_base;
							state <= S_READ_SIZE;
						end
					end
				end
			end
			S_DRAIN: begin
				drain_cnt <= drain_cnt + 1'b1;
				if (drain_cnt == DRAIN_W'(conv_pkg::DRAIN_CYCLES - 1)) begin
					state <= S_IDLE;
				end
			end
			default: begin
				state <= S_IDLE;
			end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== verilog/mac_lane.sv ====
`timescale 1ns/100ps
`default_nettype none

module mac_lane (
	input  wire logic clk,
	input  wire logic reset_b,
	input  wire logic mac_clear,
	input  wire logic mac_en,
	input  wire conv_pkg::pixel_t weight,
	input  wire conv_pkg::pixel_t pixel,
	output conv_pkg::acc_t acc
);

	logic signed [15:0] product;

	// Signed 8x8 product, sign extended into the sum
	assign product = weight * pixel;

	always_ff @(posedge clk) begin
		if (!reset_b) begin
			acc <= '0;
		end else if (mac_clear) begin
			acc <= '0;
		end else if (mac_en) begin
			acc <= acc + product;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/conv_pkg.sv ====
`default_nettype none

package conv_pkg;

	// ------------------------------------------------------------------------
	// Widths
	// ------------------------------------------------------------------------

	// Default SRAM address width, overridden through module parameters
	localparam int ADDR_W = 12;
	localparam int DATA_W = 16;

	typedef logic signed [7:0] pixel_t;
	typedef logic signed [19:0] acc_t;

	// One input SRAM word: either a matrix size word or two pixels,
	// even column in the low byte
	typedef union packed {
		logic [DATA_W-1:0] size;
		pixel_t [1:0] pair;
	} sram_word_t;

	// ------------------------------------------------------------------------
	// Fixed constants
	// ------------------------------------------------------------------------

	// Size word that closes the matrix chain
	localparam logic [DATA_W-1:0] END_MARKER = '1;

	// Conv outputs under one 2x2 pool window
	localparam int LANES = 4;
	localparam int KERNEL_TAPS = 9;

	// Words in one 4x4 patch, two pixels each
	localparam int PATCH_WORDS = 8;

	localparam int RELU_MAX = 127;

	// Cycles from end marker to busy low
	localparam int DRAIN_CYCLES = 16;

endpackage

`default_nettype wire
